// ==== sim/cart_checker.sv ====
module cart_checker import cart_pkg::*; (
  input  logic           CLK2,
  input  logic           rst,
  input  int             test_num,
  input  logic           test_end,
  input  logic           all_done,
  input  snes_addr_t     snes_addr_in,
  input  logic           rom_hit,
  input  logic           mcu_rrq,
  input  logic           mcu_wrq,
  input  snes_addr_t     mcu_addr,
  input  byte_t          mcu_dout,
  input  byte_t          mcu_din,
  input  logic           mcu_rdy,
  input  logic           cx4_active,
  input  logic           cx4_rrq,
  input  snes_addr_t     cx4_addr,
  input  byte_t          cx4_din,
  input  logic           cx4_rdy,
  input  rom_word_addr_t rom_addr,
  input  logic           rom_we,
  input  logic           rom_dout_en,
  output int             err_total
);
  timeunit 1ns;
  timeprecision 100ps;

  byte_t      shadow [8192];
  bit         written [8192];  // Shadow byte valid, else initial fill
  snes_addr_t addr_hist [4];
  int         hist_fill;
  logic       rst_q = 1'b0;
  logic       mcu_rdy_q = 1'b1;
  logic       cx4_rdy_q = 1'b1;
  logic       mcu_busy = 1'b0;
  logic       mcu_is_wr = 1'b0;
  logic       cx4_busy = 1'b0;
  logic       mcu_behind_cx4 = 1'b0;
  snes_addr_t mcu_pend_addr;
  snes_addr_t cx4_pend_addr;
  int         mcu_wait;
  int         test_checks;
  int         test_errs;
  int         checks_total;

  function automatic rom_word_t fill_pattern(input rom_word_addr_t w);
    return w[15:0] ^ {w[22:16], 9'h000} ^ 16'hc35a;
  endfunction

  // Odd byte address lives in the low half of the word
  function automatic byte_t expected_byte(input snes_addr_t b);
    rom_word_t w;
    w = fill_pattern(rom_word_addr_t'(b[23:1]));
    if (written[b[12:0]]) return shadow[b[12:0]];
    return b[0] ? w[7:0] : w[15:8];
  endfunction

  function automatic string test_name(input int n);
    case (n)
      1: return "reset values";
      2: return "dead-mode MCU access";
      3: return "free-slot MCU access";
      4: return "coprocessor priority";
      5: return "console mapping";
      default: return "unknown";
    endcase
  endfunction

  task automatic record_check(input logic ok, input string msg);
    test_checks++;
    checks_total++;
    if (!ok) begin
      test_errs++;
      err_total++;
      $display("ERROR %0t: %s", $time, msg);
    end
  endtask

  always @(posedge CLK2) begin
    snes_addr_t filt;
    snes_addr_t mapped;
    if (rst) begin
      mcu_busy = 1'b0;
      cx4_busy = 1'b0;
    end else begin
      if (rst_q) begin
        record_check(mcu_rdy && cx4_rdy && rom_we && !rom_dout_en,
                     "outputs after reset are not ready high, rom_we high, dout_en low");
      end
      //////////////////////////////////////////////////////////
      // Console mapping through the four-stage address filter
      //////////////////////////////////////////////////////////
      if (hist_fill >= 4) begin
        filt = addr_hist[3] & addr_hist[2];
        record_check(rom_hit === (filt[22] | filt[15]),
                     $sformatf("rom_hit %b for console address %h", rom_hit, filt));
        if (mcu_rdy && cx4_rdy) begin  // Nothing pending, so idle
          // Bits above 15 move down one place, bit 15 is gone
          mapped = (((filt >> 1) & 24'h7f_8000) | (filt & 24'h00_7fff)) & rom_size_mask;
          record_check(rom_addr === mapped[23:1],
                       $sformatf("idle rom_addr %h, expected %h", rom_addr, mapped[23:1]));
        end
      end
      if (!rom_we) begin
        record_check(mcu_busy && mcu_is_wr, "rom_we low without an MCU write in progress");
      end
      // Data bus driven exactly during the write strobe
      record_check(rom_dout_en === !rom_we,
                   $sformatf("rom_dout_en %b while rom_we is %b", rom_dout_en, rom_we));
      if (mcu_busy) mcu_wait++;

      if (cx4_rdy && !cx4_rdy_q && cx4_busy) begin
        record_check(cx4_din === expected_byte(cx4_pend_addr),
                     $sformatf("coprocessor read %h returned %h, expected %h",
                               cx4_pend_addr, cx4_din, expected_byte(cx4_pend_addr)));
        cx4_busy = 1'b0;
      end
      if (mcu_rdy && !mcu_rdy_q && mcu_busy) begin
        if (!mcu_is_wr) begin
          record_check(mcu_din === expected_byte(mcu_pend_addr),
                       $sformatf("MCU read %h returned %h, expected %h",
                                 mcu_pend_addr, mcu_din, expected_byte(mcu_pend_addr)));
        end
        if (test_num == 2) begin
          record_check(mcu_wait <= 12, $sformatf("MCU ready took %0d cycles", mcu_wait));
        end
        if (mcu_behind_cx4) begin
          record_check(!cx4_busy, "MCU read finished before the coprocessor read");
        end
        mcu_busy = 1'b0;
      end

      // New requests
      if (mcu_rrq || mcu_wrq) begin
        record_check(!mcu_busy, "MCU request before the previous access completed");
        mcu_busy       = 1'b1;
        mcu_is_wr      = mcu_wrq;
        mcu_pend_addr  = mcu_addr;
        mcu_wait       = 0;
        mcu_behind_cx4 = cx4_active && cx4_rrq;
        if (mcu_wrq) begin
          shadow[mcu_addr[12:0]]  = mcu_dout;
          written[mcu_addr[12:0]] = 1'b1;
        end
      end
      if (cx4_active && cx4_rrq) begin
        record_check(!cx4_busy, "coprocessor request before the previous read completed");
        cx4_busy      = 1'b1;
        cx4_pend_addr = cx4_addr;
      end
    end

    if (test_end) begin
      if (test_checks == 0) begin
        test_errs++;
        err_total++;
        $display("Test %0d ran no checks at all", test_num);
      end
      $display("Test %0d (%s): %0d checks, %0d errors",
               test_num, test_name(test_num), test_checks, test_errs);
      test_checks = 0;
      test_errs   = 0;
    end
    if (all_done) begin
      $display("Summary: %0d checks, %0d errors", checks_total, err_total);
    end

    // Mirror of the DUT address pipeline, also during reset
    addr_hist[3] = addr_hist[2];
    addr_hist[2] = addr_hist[1];
    addr_hist[1] = addr_hist[0];
    addr_hist[0] = snes_addr_in;
    if (hist_fill < 4) hist_fill++;
    rst_q     = rst;
    mcu_rdy_q = mcu_rdy;
    cx4_rdy_q = cx4_rdy;
  end

endmodule

// ==== sim/cart_main_assert.sv ====
module cart_main_assert (
  input logic CLK2,
  input logic rst,
  input logic mcu_rrq,
  input logic mcu_wrq,
  input logic mcu_rdy,
  input logic cx4_active,
  input logic cx4_rrq,
  input logic cx4_rdy,
  input logic rom_we
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  ////////////////////////////////////////////////////////////
  // Request handshake
  ////////////////////////////////////////////////////////////
  mcu_strobe_when_ready: assert property (@(posedge CLK2) disable iff (rst)
    (mcu_rrq || mcu_wrq) |-> mcu_rdy)
    else begin
      $error("MCU request strobe while mcu_rdy is low");
      fail_count++;
    end

  mcu_single_strobe: assert property (@(posedge CLK2) disable iff (rst)
    !(mcu_rrq && mcu_wrq))
    else begin
      $error("MCU read and write strobes together");
      fail_count++;
    end

  cx4_strobe_when_ready: assert property (@(posedge CLK2) disable iff (rst)
    (cx4_active && cx4_rrq) |-> cx4_rdy)
    else begin
      $error("Coprocessor request strobe while cx4_rdy is low");
      fail_count++;
    end

  // Write enable only inside an MCU access
  we_only_when_busy: assert property (@(posedge CLK2) disable iff (rst)
    !rom_we |-> !mcu_rdy)
    else begin
      $error("rom_we low while mcu_rdy is high");
      fail_count++;
    end

endmodule

bind rom_arbiter cart_main_assert u_assert (
  .CLK2       (CLK2),
  .rst        (rst),
  .mcu_rrq    (mcu_rrq),
  .mcu_wrq    (mcu_wrq),
  .mcu_rdy    (mcu_rdy),
  .cx4_active (cx4_active),
  .cx4_rrq    (cx4_rrq),
  .cx4_rdy    (cx4_rdy),
  .rom_we     (rom_we)
);

// ==== sim/tb_cart_main.sv ====
module tb_cart_main import cart_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int psram_words     = 4096;
  localparam int watchdog_cycles = int'(snes_dead_timeout) + 400 * 40;

  logic           CLK2 = 1'b0;
  logic           rst;
  logic           snes_cpu_clk_in = 1'b0;
  snes_addr_t     snes_addr_in = 24'h00_8000;
  logic           console_run = 1'b0;
  int             half_cnt = 0;
  logic           rom_hit;
  logic           mcu_rrq;
  logic           mcu_wrq;
  snes_addr_t     mcu_addr;
  byte_t          mcu_dout;
  byte_t          mcu_din;
  logic           mcu_rdy;
  logic           cx4_active;
  logic           cx4_rrq;
  snes_addr_t     cx4_addr;
  byte_t          cx4_din;
  logic           cx4_rdy;
  rom_word_addr_t rom_addr;
  rom_word_t      rom_data_in;
  rom_word_t      rom_data_out;
  logic           rom_dout_en;
  logic           rom_we;
  logic           rom_bhe;
  logic           rom_ble;
  rom_word_t      psram [psram_words];
  int             test_num;
  logic           test_end;
  logic           all_done;
  int             err_total;
  int             assert_fails;

  always #4 CLK2 = ~CLK2;

  cart_main u_cart_main (.*);

  cart_checker u_checker (
    .CLK2         (CLK2),
    .rst          (rst),
    .test_num     (test_num),
    .test_end     (test_end),
    .all_done     (all_done),
    .snes_addr_in (snes_addr_in),
    .rom_hit      (rom_hit),
    .mcu_rrq      (mcu_rrq),
    .mcu_wrq      (mcu_wrq),
    .mcu_addr     (mcu_addr),
    .mcu_dout     (mcu_dout),
    .mcu_din      (mcu_din),
    .mcu_rdy      (mcu_rdy),
    .cx4_active   (cx4_active),
    .cx4_rrq      (cx4_rrq),
    .cx4_addr     (cx4_addr),
    .cx4_din      (cx4_din),
    .cx4_rdy      (cx4_rdy),
    .rom_addr     (rom_addr),
    .rom_we       (rom_we),
    .rom_dout_en  (rom_dout_en),
    .err_total    (err_total)
  );

  function automatic rom_word_t fill_pattern(input rom_word_addr_t w);
    return w[15:0] ^ {w[22:16], 9'h000} ^ 16'hc35a;
  endfunction

  function automatic snes_addr_t rand_addr(input int span);
    return snes_addr_t'($urandom % span);
  endfunction

  ////////////////////////////////////////////////////////////
  // PSRAM model
  ////////////////////////////////////////////////////////////
  assign rom_data_in = psram[rom_addr[11:0]];

  always @(posedge CLK2) begin
    if (!rom_we) begin
      if (!rom_bhe) psram[rom_addr[11:0]][15:8] <= rom_data_out[15:8];
      if (!rom_ble) psram[rom_addr[11:0]][7:0] <= rom_data_out[7:0];  // Odd byte
    end
  end

  // Console clock with a random half period, new address at each falling edge
  always @(posedge CLK2) begin
    if (console_run) begin
      if (half_cnt == 0) begin
        snes_cpu_clk_in <= ~snes_cpu_clk_in;
        half_cnt        <= 5 + int'($urandom % 4);
        if (snes_cpu_clk_in) begin
          snes_addr_in <= snes_addr_t'($urandom);
        end
      end else begin
        half_cnt <= half_cnt - 1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Request tasks
  ////////////////////////////////////////////////////////////
  task automatic mcu_access(input logic wr, input snes_addr_t addr, input byte_t data);
    mcu_addr <= addr;
    mcu_dout <= data;  // Held until ready returns
    if (wr) mcu_wrq <= 1'b1;
    else mcu_rrq <= 1'b1;
    @(posedge CLK2);
    mcu_rrq <= 1'b0;
    mcu_wrq <= 1'b0;
    do @(posedge CLK2); while (!mcu_rdy);
  endtask

  task automatic cx4_read(input snes_addr_t addr, input logic with_mcu, input snes_addr_t maddr);
    cx4_addr <= addr;
    cx4_rrq  <= 1'b1;
    if (with_mcu) begin
      mcu_addr <= maddr;
      mcu_rrq  <= 1'b1;  // Same edge as the coprocessor
    end
    @(posedge CLK2);
    cx4_rrq <= 1'b0;
    mcu_rrq <= 1'b0;
    do @(posedge CLK2); while (!(cx4_rdy && mcu_rdy));
  endtask

  task automatic close_test();
    test_end <= 1'b1;
    @(posedge CLK2);
    test_end <= 1'b0;
    test_num <= test_num + 1;
    @(posedge CLK2);
  endtask

  initial begin
    void'($urandom(61));
    rst        = 1'b1;
    mcu_rrq    = 1'b0;
    mcu_wrq    = 1'b0;
    mcu_addr   = '0;
    mcu_dout   = '0;
    cx4_active = 1'b0;
    cx4_rrq    = 1'b0;
    cx4_addr   = '0;
    test_num   = 1;
    test_end   = 1'b0;
    all_done   = 1'b0;
    for (int i = 0; i < psram_words; i++) begin
      psram[i] = fill_pattern(rom_word_addr_t'(i));
    end
    repeat (5) @(posedge CLK2);
    rst <= 1'b0;
    repeat (3) @(posedge CLK2);
    close_test();

    // Console clock stays low well past the timeout
    repeat (int'(snes_dead_timeout) + 16) @(posedge CLK2);
    for (int n = 0; n < 100; n++) begin
      mcu_access(($urandom % 2) == 1, rand_addr(256), byte_t'($urandom));
    end
    close_test();

    console_run <= 1'b1;
    repeat (40) @(posedge CLK2);
    for (int n = 0; n < 100; n++) begin
      mcu_access(($urandom % 2) == 1, rand_addr(256), byte_t'($urandom));
    end
    close_test();

    cx4_active <= 1'b1;
    @(posedge CLK2);
    for (int n = 0; n < 40; n++) begin
      cx4_read(rand_addr(8192), (n % 2) == 1, rand_addr(256));
    end
    cx4_active <= 1'b0;
    close_test();

    repeat (200) @(posedge CLK2);  // Idle, console mapping only
    close_test();

    all_done <= 1'b1;
    @(posedge CLK2);
    all_done <= 1'b0;
    repeat (2) @(posedge CLK2);
    assert_fails = u_cart_main.u_arbiter.u_assert.fail_count;
    if (assert_fails != 0) begin
      $display("%0d assertion failures in the arbiter", assert_fails);
    end
    if (err_total == 0 && assert_fails == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (watchdog_cycles) @(posedge CLK2);
    $display("Timeout after %0d cycles, a request never completed", watchdog_cycles);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== verilog.f ====
verilog/cart_pkg.sv
verilog/snes_bus_if.sv
verilog/mem_cycle_if.sv
verilog/snes_bus_decode.sv
verilog/rom_arbiter.sv
verilog/rom_data_path.sv
verilog/cart_main.sv
sim/cart_main_assert.sv
sim/cart_checker.sv
sim/tb_cart_main.sv

// ==== verilog/cart_main.sv ====
module cart_main import cart_pkg::*; (
  input  logic           CLK2,
  input  logic           rst,
  // Console side
  input  logic           snes_cpu_clk_in,
  input  snes_addr_t     snes_addr_in,
  output logic           rom_hit,
  // MCU requests
  input  logic           mcu_rrq,
  input  logic           mcu_wrq,
  input  snes_addr_t     mcu_addr,
  input  byte_t          mcu_dout,
  output byte_t          mcu_din,
  output logic           mcu_rdy,
  // Coprocessor requests
  input  logic           cx4_active,
  input  logic           cx4_rrq,
  input  snes_addr_t     cx4_addr,
  output byte_t          cx4_din,
  output logic           cx4_rdy,
  // PSRAM
  output rom_word_addr_t rom_addr,
  input  rom_word_t      rom_data_in,
  output rom_word_t      rom_data_out,
  output logic           rom_dout_en,
  output logic           rom_we,
  output logic           rom_bhe,
  output logic           rom_ble
);

  logic cpu_clk_alive;

  snes_bus_if  bus ();
  mem_cycle_if cyc ();

  snes_bus_decode u_decode (
    .CLK2            (CLK2),
    .rst             (rst),
    .snes_cpu_clk_in (snes_cpu_clk_in),
    .snes_addr_in    (snes_addr_in),
    .rom_hit         (rom_hit),
    .cpu_clk_alive   (cpu_clk_alive),
    .bus             (bus.decode)
  );

  rom_arbiter u_arbiter (
    .CLK2          (CLK2),
    .rst           (rst),
    .mcu_rrq       (mcu_rrq),
    .mcu_wrq       (mcu_wrq),
    .mcu_addr      (mcu_addr),
    .cx4_active    (cx4_active),
    .cx4_rrq       (cx4_rrq),
    .cx4_addr      (cx4_addr),
    .cpu_clk_alive (cpu_clk_alive),
    .mcu_rdy       (mcu_rdy),
    .cx4_rdy       (cx4_rdy),
    .rom_addr      (rom_addr),
    .rom_we        (rom_we),
    .bus           (bus.arbiter),
    .cyc           (cyc.arbiter)
  );

  rom_data_path u_data_path (
    .CLK2         (CLK2),
    .rom_data_in  (rom_data_in),
    .mcu_dout     (mcu_dout),
    .mcu_din      (mcu_din),
    .cx4_din      (cx4_din),
    .rom_data_out (rom_data_out),
    .rom_dout_en  (rom_dout_en),
    .rom_bhe      (rom_bhe),
    .rom_ble      (rom_ble),
    .cyc          (cyc.data_path)
  );

endmodule

// ==== verilog/cart_pkg.sv ====
package cart_pkg;

  ////////////////////////////////////////////////////////////
  // Bus and memory widths
  ////////////////////////////////////////////////////////////
  typedef logic [23:0] snes_addr_t;      // Console / MCU byte address
  typedef logic [22:0] rom_word_addr_t;  // PSRAM word address
  typedef logic [15:0] rom_word_t;
  typedef logic [7:0]  byte_t;
  typedef logic [3:0]  delay_cnt_t;
  typedef logic [17:0] dead_cnt_t;

  ////////////////////////////////////////////////////////////
  // Timing and mapping constants
  ////////////////////////////////////////////////////////////
  localparam delay_cnt_t rom_cycle_len     = 4'd7;      // Address state lasts this + 1
  localparam dead_cnt_t  snes_dead_timeout = 18'd88000; // About 1 ms of CLK2
  localparam int         sync_depth        = 8;         // CPU clock shift register
  localparam int         addr_sync_depth   = 4;         // Address pipeline stages

  // 4 MB ROM image
  localparam snes_addr_t rom_size_mask = 24'h3f_ffff;

  typedef enum logic [2:0] {
    idle,
    mcu_rd_addr,
    mcu_rd_end,
    mcu_wr_addr,
    mcu_wr_end,
    cx4_rd_addr,
    cx4_rd_end
  } arb_state_t;

endpackage

// ==== verilog/mem_cycle_if.sv ====
interface mem_cycle_if ();

  // Each active flag is high for the whole address state
  logic mcu_rd_active;
  logic mcu_wr_active;
  logic cx4_rd_active;
  logic byte_sel;  // Bit 0 of the byte address in use

  modport arbiter (
    output mcu_rd_active, mcu_wr_active, cx4_rd_active, byte_sel
  );

  modport data_path (
    input mcu_rd_active, mcu_wr_active, cx4_rd_active, byte_sel
  );

endinterface

// ==== verilog/rom_arbiter.sv ====
module rom_arbiter import cart_pkg::*; (
  input  logic           CLK2,
  input  logic           rst,
  input  logic           mcu_rrq,
  input  logic           mcu_wrq,
  input  snes_addr_t     mcu_addr,
  input  logic           cx4_active,
  input  logic           cx4_rrq,
  input  snes_addr_t     cx4_addr,
  input  logic           cpu_clk_alive,
  output logic           mcu_rdy,
  output logic           cx4_rdy,
  output rom_word_addr_t rom_addr,
  output logic           rom_we,
  snes_bus_if.arbiter    bus,
  mem_cycle_if.arbiter   cyc
);

  arb_state_t state;
  delay_cnt_t delay_cnt;
  logic       mcu_rd_pend;
  logic       mcu_wr_pend;
  logic       cx4_rd_pend;
  snes_addr_t mcu_addr_r;
  snes_addr_t cx4_addr_r;
  snes_addr_t sel_addr;
  logic       mcu_hit;
  logic       cx4_hit;

  ////////////////////////////////////////////////////////////
  // Request latches
  ////////////////////////////////////////////////////////////
  always_ff @(posedge CLK2) begin
    if (rst) begin
      mcu_rd_pend <= 1'b0;
      mcu_wr_pend <= 1'b0;
      mcu_rdy     <= 1'b1;
    end else if (mcu_rrq) begin
      mcu_rd_pend <= 1'b1;
      mcu_rdy     <= 1'b0;
    end else if (mcu_wrq) begin
      mcu_wr_pend <= 1'b1;
      mcu_rdy     <= 1'b0;
    end else if (state == mcu_rd_end || state == mcu_wr_end) begin
      mcu_rd_pend <= 1'b0;
      mcu_wr_pend <= 1'b0;
      mcu_rdy     <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (rst) begin
      cx4_rd_pend <= 1'b0;
      cx4_rdy     <= 1'b1;
    end else if (cx4_active && cx4_rrq) begin
      cx4_rd_pend <= 1'b1;
      cx4_rdy     <= 1'b0;
    end else if (state == cx4_rd_end) begin
      cx4_rd_pend <= 1'b0;
      cx4_rdy     <= 1'b1;
    end
  end

  // Request addresses, captured with the strobe
  always_ff @(posedge CLK2) begin
    if (mcu_rrq || mcu_wrq) mcu_addr_r <= mcu_addr;
    if (cx4_active && cx4_rrq) cx4_addr_r <= cx4_addr;
  end

  ////////////////////////////////////////////////////////////
  // Arbitration FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge CLK2) begin
    if (rst) begin
      state     <= idle;
      delay_cnt <= '0;
    end else if (bus.dead && cpu_clk_alive) begin
      state <= idle;  // Console is back, drop the access and redo it later
    end else begin
      case (state)
        idle: begin
          if (cx4_active && cx4_rd_pend) begin
            state     <= cx4_rd_addr;
            delay_cnt <= rom_cycle_len;
          end else if (bus.free_slot || bus.dead) begin
            if (mcu_rd_pend) begin
              state     <= mcu_rd_addr;
              delay_cnt <= rom_cycle_len;
            end else if (mcu_wr_pend) begin
              state     <= mcu_wr_addr;
              delay_cnt <= rom_cycle_len;
            end
          end
        end
        mcu_rd_addr, mcu_wr_addr, cx4_rd_addr: begin
          delay_cnt <= delay_cnt - 1'b1;
          if (delay_cnt == '0) begin
            case (state)
              mcu_rd_addr: state <= mcu_rd_end;
              mcu_wr_addr: state <= mcu_wr_end;
              default:     state <= cx4_rd_end;
            endcase
          end
        end
        default: state <= idle;  // End states last one cycle
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // PSRAM address and control
  ////////////////////////////////////////////////////////////
  assign mcu_hit = (state == mcu_rd_addr) || (state == mcu_wr_addr);
  assign cx4_hit = (state == cx4_rd_addr);

  assign sel_addr = mcu_hit ? mcu_addr_r :
                    cx4_hit ? cx4_addr_r :
                              bus.mapped_addr;

  assign rom_addr = sel_addr[23:1];
  assign rom_we   = (state != mcu_wr_addr);  // Active low

  assign cyc.mcu_rd_active = (state == mcu_rd_addr);
  assign cyc.mcu_wr_active = (state == mcu_wr_addr);
  assign cyc.cx4_rd_active = cx4_hit;
  assign cyc.byte_sel      = sel_addr[0];

endmodule

// ==== verilog/rom_data_path.sv ====
module rom_data_path import cart_pkg::*; (
  input  logic            CLK2,
  input  rom_word_t       rom_data_in,
  input  byte_t           mcu_dout,
  output byte_t           mcu_din,
  output byte_t           cx4_din,
  output rom_word_t       rom_data_out,
  output logic            rom_dout_en,
  output logic            rom_bhe,
  output logic            rom_ble,
  mem_cycle_if.data_path  cyc
);

  byte_t rd_byte;

  ////////////////////////////////////////////////////////////
  // Byte lanes
  ////////////////////////////////////////////////////////////
  // Odd address sits in the low byte of the word
  assign rd_byte = cyc.byte_sel ? rom_data_in[7:0] : rom_data_in[15:8];

  assign rom_bhe = cyc.byte_sel;   // Active low strobes
  assign rom_ble = ~cyc.byte_sel;

  ////////////////////////////////////////////////////////////
  // Read capture
  ////////////////////////////////////////////////////////////
  // Last address-state sample is the one that stays
  always_ff @(posedge CLK2) begin
    if (cyc.mcu_rd_active) begin
      mcu_din <= rd_byte;
    end
    if (cyc.cx4_rd_active) begin
      cx4_din <= rd_byte;
    end
  end

  // Write byte goes to both halves, lane strobes pick one
  assign rom_data_out = {mcu_dout, mcu_dout};
  assign rom_dout_en  = cyc.mcu_wr_active;

endmodule

// ==== verilog/snes_bus_decode.sv ====
module snes_bus_decode import cart_pkg::*; (
  input  logic         CLK2,
  input  logic         rst,
  input  logic         snes_cpu_clk_in,
  input  snes_addr_t   snes_addr_in,
  output logic         rom_hit,
  output logic         cpu_clk_alive,
  snes_bus_if.decode   bus
);

  logic [sync_depth-1:0] cpu_clk_r;
  snes_addr_t            addr_r [addr_sync_depth];
  snes_addr_t            snes_addr;
  logic                  cpu_clk;
  logic                  free_strobe;
  logic                  dead_r;
  dead_cnt_t             dead_cnt;

  ////////////////////////////////////////////////////////////
  // Input conditioning
  ////////////////////////////////////////////////////////////
  always_ff @(posedge CLK2) begin
    if (rst) begin
      cpu_clk_r <= '0;
    end else begin
      cpu_clk_r <= {cpu_clk_r[sync_depth-2:0], snes_cpu_clk_in};
    end
  end

  always_ff @(posedge CLK2) begin
    addr_r[0] <= snes_addr_in;
    for (int i = 1; i < addr_sync_depth; i++) begin
      addr_r[i] <= addr_r[i-1];
    end
  end

  // Two-sample AND rejects single-cycle glitches
  assign cpu_clk   = cpu_clk_r[2] & cpu_clk_r[1];
  assign snes_addr = addr_r[addr_sync_depth-1] & addr_r[addr_sync_depth-2];
  assign cpu_clk_alive = cpu_clk;

  // Edge windows over four filtered samples
  assign bus.cycle_start = ((cpu_clk_r[4:1] & cpu_clk_r[5:2]) == 4'b0001);
  assign bus.cycle_end   = ((cpu_clk_r[4:1] & cpu_clk_r[5:2]) == 4'b1110);

  ////////////////////////////////////////////////////////////
  // LoROM mapping
  ////////////////////////////////////////////////////////////
  assign rom_hit         = snes_addr[22] | snes_addr[15];
  assign bus.mapped_addr = {1'b0, snes_addr[23:16], snes_addr[14:0]} & rom_size_mask;

  // Non-ROM cycle leaves the PSRAM idle right after its start
  always_ff @(posedge CLK2) begin
    if (rst) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= bus.cycle_start & ~rom_hit;
    end
  end

  assign bus.free_slot = bus.cycle_end | free_strobe;

  ////////////////////////////////////////////////////////////
  // Console-dead detection
  ////////////////////////////////////////////////////////////
  always_ff @(posedge CLK2) begin
    if (rst) begin
      dead_cnt <= '0;
      dead_r   <= 1'b1;
    end else begin
      if (cpu_clk) begin
        dead_cnt <= '0;
      end else if (dead_cnt <= snes_dead_timeout) begin
        dead_cnt <= dead_cnt + 1'b1;  // Stops one past the timeout
      end
      if (cpu_clk) begin
        dead_r <= 1'b0;
      end else if (dead_cnt > snes_dead_timeout) begin
        dead_r <= 1'b1;
      end
    end
  end

  assign bus.dead = dead_r;

endmodule

// ==== verilog/snes_bus_if.sv ====
interface snes_bus_if import cart_pkg::*; ();

  logic       cycle_start;  // Rising CPU clock, one cycle
  logic       cycle_end;    // Falling CPU clock, one cycle
  logic       free_slot;
  logic       dead;         // Console clock stopped
  snes_addr_t mapped_addr;

  modport decode (
    output cycle_start, cycle_end, free_slot, dead, mapped_addr
  );

  modport arbiter (
    input cycle_start, cycle_end, free_slot, dead, mapped_addr
  );

endinterface
